/* Makefile */
# Verilator build and run of the standby I2C flow testbench

VERILATOR ?= verilator
TOP       ?= i2c_standby_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "STATUS: PASS" $(LOG); then \
	  echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
src/i2c_standby_pkg.sv
src/tti_queue.sv
src/i2c_standby_flow.sv
src/i2c_standby_top.sv
test/i2c_standby_props.sv
test/i2c_standby_tb.sv

/* src/i2c_standby_flow.sv */
// Sequencer of standby-mode I2C write and read transfers between acquisition stream and queues
`timescale 1ns/1ps
`default_nettype none

module i2c_standby_flow
  import i2c_standby_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           acq_valid_i,
  input  acq_word_t      acq_word_i,
  output logic           byte_valid_o,
  output logic [7:0]     byte_data_o,
  input  logic           byte_ready_i,
  input  logic           cmd_rvalid_i,
  input  tti_cmd_desc_t  cmd_rdata_i,
  output logic           cmd_rready_o,
  input  logic           tx_rvalid_i,
  input  dword_t         tx_rdata_i,
  output logic           tx_rready_o,
  output logic           rx_wvalid_o,
  output dword_t         rx_wdata_o,
  input  logic           rx_wready_i,
  output logic           resp_wvalid_o,
  output tti_resp_desc_t resp_wdata_o,
  input  logic           resp_wready_i,
  output logic           err_o
);

  localparam int LaneBits = $clog2(DwordBytes);
  localparam logic [LaneBits-1:0] LastLane = LaneBits'(DwordBytes - 1);

  typedef enum logic [3:0] {
    AwaitStart         = 4'd0,
    ReceiveByte        = 4'd1,
    PushDword          = 4'd2,
    PushResponse       = 4'd3,
    PopCommand         = 4'd4,
    PopDword           = 4'd5,
    SendByte           = 4'd6,
    SwitchByte         = 4'd7,
    AwaitStopOrRestart = 4'd8,
    ReportError        = 4'd9
  } state_e;

  state_e state_q, state_d;
  state_e start_state;

  // Transfer bookkeeping
  xfer_len_t           byte_cnt_q;
  xfer_len_t           read_len_q;
  xfer_len_t           resp_len_q;
  dword_t              dword_q;
  logic                xfer_active_q;
  logic [LaneBits-1:0] lane;

  // Decoded acquisition strobe
  acq_byte_id_e acq_id;
  logic         data_det;
  logic         start_det;
  logic         end_det;
  logic         nack_det;
  logic         read_start;

  // Register controls from the FSM
  logic push_byte;
  logic store_byte;
  logic take_start;
  logic end_xfer;
  logic pop_cmd;
  logic pop_tx;

  assign acq_id     = acq_word_i.id;
  assign data_det   = acq_valid_i & (acq_id == AcqData);
  assign end_det    = acq_valid_i & ((acq_id == AcqStop) | (acq_id == AcqRestart));
  assign nack_det   = acq_valid_i & (acq_id == AcqNack);
  assign start_det  = acq_valid_i &
                      ((acq_id == AcqStart) | (acq_id == AcqRestart) | (acq_id == AcqNackStart));
  // Plain start begins a write, the repeated start kinds begin a read
  assign read_start = (acq_id != AcqStart);

  assign start_state = !start_det ? AwaitStart : (read_start ? PopCommand : ReceiveByte);

  assign lane         = byte_cnt_q[LaneBits-1:0];
  assign byte_data_o  = dword_q[lane*8 +: 8];
  assign rx_wdata_o   = dword_q;
  assign resp_wdata_o = '{err: 1'b0, reserved: '0, data_length: resp_len_q};
  assign pop_cmd      = cmd_rready_o & cmd_rvalid_i;
  assign pop_tx       = tx_rready_o & tx_rvalid_i;

  always_comb begin
    state_d       = state_q;
    byte_valid_o  = 1'b0;
    cmd_rready_o  = 1'b0;
    tx_rready_o   = 1'b0;
    rx_wvalid_o   = 1'b0;
    resp_wvalid_o = 1'b0;
    err_o         = 1'b0;
    push_byte     = 1'b0;
    store_byte    = 1'b0;
    take_start    = 1'b0;
    end_xfer      = 1'b0;

    unique case (state_q)
      AwaitStart: begin
        state_d    = start_state;
        take_start = start_det;
      end
      ReceiveByte: begin
        if (end_det) begin
          end_xfer = 1'b1;
          state_d  = (lane != '0) ? PushDword : PushResponse;
        end else if (data_det) begin
          push_byte  = 1'b1;
          store_byte = 1'b1;
          if (lane == LastLane) state_d = PushDword;
        end else if (acq_valid_i) begin
          state_d = ReportError;
        end
      end
      PushDword: begin
        rx_wvalid_o = 1'b1;
        end_xfer    = end_det & xfer_active_q;
        if (rx_wready_i) begin
          if (!xfer_active_q || end_det) begin
            state_d = PushResponse;
          end else if (data_det) begin
            // The pushed dword leaves on this edge, so lane 0 can be refilled
            push_byte  = 1'b1;
            store_byte = 1'b1;
            state_d    = ReceiveByte;
          end else begin
            state_d = acq_valid_i ? ReportError : ReceiveByte;
          end
        end else if (acq_valid_i && !end_det) begin
          state_d = ReportError;
        end
      end
      PushResponse: begin
        resp_wvalid_o = 1'b1;
        if (resp_wready_i) begin
          state_d    = start_state;
          take_start = start_det;
        end else if (acq_valid_i && !end_det) begin
          state_d = ReportError;
        end
      end
      PopCommand: begin
        cmd_rready_o = 1'b1;
        // First TX dword is taken together with a usable command
        tx_rready_o  = cmd_rvalid_i & (cmd_rdata_i.data_length != '0);
        if (cmd_rvalid_i) begin
          if (cmd_rdata_i.data_length == '0) state_d = ReportError;
          else state_d = tx_rvalid_i ? SendByte : PopDword;
        end
        if (nack_det) state_d = ReportError;
      end
      PopDword: begin
        tx_rready_o = 1'b1;
        if (tx_rvalid_i) state_d = SendByte;
        if (nack_det) state_d = ReportError;
      end
      SendByte: begin
        byte_valid_o = 1'b1;
        if (byte_ready_i) begin
          push_byte = 1'b1;
          if (xfer_len_t'(byte_cnt_q + 1'b1) == read_len_q) state_d = AwaitStopOrRestart;
          else state_d = SwitchByte;
        end
        if (nack_det) state_d = ReportError;
      end
      SwitchByte: begin
        state_d = (lane == '0) ? PopDword : SendByte;
        if (nack_det) state_d = ReportError;
      end
      AwaitStopOrRestart: begin
        if (end_det) state_d = AwaitStart;
        else if (nack_det) state_d = ReportError;
      end
      ReportError: begin
        err_o = 1'b1;
      end
      default: begin
        state_d = ReportError;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= AwaitStart;
      byte_cnt_q    <= '0;
      xfer_active_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (take_start) byte_cnt_q <= '0;
      else if (push_byte) byte_cnt_q <= byte_cnt_q + 1'b1;
      if (take_start) xfer_active_q <= !read_start;
      else if (end_xfer) xfer_active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_tx) begin
      dword_q <= tx_rdata_i;
    end else if (store_byte) begin
      // Lane 0 opens a fresh dword, which zero-pads a partial one
      if (lane == '0) dword_q <= dword_t'(acq_word_i.data);
      else dword_q[lane*8 +: 8] <= acq_word_i.data;
    end
    if (pop_cmd) read_len_q <= cmd_rdata_i.data_length;
    if (end_xfer) resp_len_q <= byte_cnt_q;
  end

endmodule

`default_nettype wire

/* src/i2c_standby_pkg.sv */
// Shared types, widths and queue depths of the standby-mode I2C target flow, imported by its RTL
`default_nettype none

package i2c_standby_pkg;

  // Widths that carry a meaning across the subsystem
  localparam int DwordWidth   = 32;
  localparam int XferLenWidth = 16;
  localparam int DwordBytes   = 4;

  // Depths of the target transaction queues
  localparam int CmdQueueDepth  = 4;
  localparam int TxQueueDepth   = 8;
  localparam int RxQueueDepth   = 8;
  localparam int RespQueueDepth = 4;

  typedef logic [DwordWidth-1:0]   dword_t;
  typedef logic [XferLenWidth-1:0] xfer_len_t;

  // Kind of item delivered by the I2C target acquisition logic
  typedef enum logic [2:0] {
    AcqData      = 3'd0,
    AcqStart     = 3'd1,
    AcqStop      = 3'd2,
    AcqRestart   = 3'd3,
    AcqNack      = 3'd4,
    AcqNackStart = 3'd5
  } acq_byte_id_e;

  typedef struct packed {
    acq_byte_id_e id;
    logic [7:0]   data;
  } acq_word_t;

  // Command descriptor written by software
  typedef struct packed {
    logic        read;
    logic [14:0] reserved;
    xfer_len_t   data_length;
  } tti_cmd_desc_t;

  // Response descriptor read back by software
  typedef struct packed {
    logic        err;
    logic [14:0] reserved;
    xfer_len_t   data_length;
  } tti_resp_desc_t;

endpackage

`default_nettype wire

/* src/i2c_standby_top.sv */
// Standby I2C target subsystem top, joining the transfer flow to its four transaction queues
`timescale 1ns/1ps
`default_nettype none

module i2c_standby_top
  import i2c_standby_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           acq_valid_i,
  input  acq_word_t      acq_word_i,
  output logic           byte_valid_o,
  output logic [7:0]     byte_data_o,
  input  logic           byte_ready_i,
  input  logic           cmd_wvalid_i,
  input  tti_cmd_desc_t  cmd_wdata_i,
  output logic           cmd_wready_o,
  input  logic           txd_wvalid_i,
  input  dword_t         txd_wdata_i,
  output logic           txd_wready_o,
  output logic           rxd_rvalid_o,
  output dword_t         rxd_rdata_o,
  input  logic           rxd_rready_i,
  output logic           resp_rvalid_o,
  output tti_resp_desc_t resp_rdata_o,
  input  logic           resp_rready_i,
  output logic           err_o
);

  // Flow side of the queues
  logic           cmd_rvalid;
  tti_cmd_desc_t  cmd_rdata;
  logic           cmd_rready;
  logic           tx_rvalid;
  dword_t         tx_rdata;
  logic           tx_rready;
  logic           rx_wvalid;
  dword_t         rx_wdata;
  logic           rx_wready;
  logic           resp_wvalid;
  tti_resp_desc_t resp_wdata;
  logic           resp_wready;

  i2c_standby_flow u_flow (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .acq_valid_i   (acq_valid_i),
    .acq_word_i    (acq_word_i),
    .byte_valid_o  (byte_valid_o),
    .byte_data_o   (byte_data_o),
    .byte_ready_i  (byte_ready_i),
    .cmd_rvalid_i  (cmd_rvalid),
    .cmd_rdata_i   (cmd_rdata),
    .cmd_rready_o  (cmd_rready),
    .tx_rvalid_i   (tx_rvalid),
    .tx_rdata_i    (tx_rdata),
    .tx_rready_o   (tx_rready),
    .rx_wvalid_o   (rx_wvalid),
    .rx_wdata_o    (rx_wdata),
    .rx_wready_i   (rx_wready),
    .resp_wvalid_o (resp_wvalid),
    .resp_wdata_o  (resp_wdata),
    .resp_wready_i (resp_wready),
    .err_o         (err_o)
  );

  // Software pushes commands and TX data
  tti_queue #(
    .Width ($bits(tti_cmd_desc_t)),
    .Depth (CmdQueueDepth)
  ) u_cmd_q (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (cmd_wvalid_i),
    .wdata_i  (cmd_wdata_i),
    .wready_o (cmd_wready_o),
    .rvalid_o (cmd_rvalid),
    .rdata_o  (cmd_rdata),
    .rready_i (cmd_rready)
  );

  tti_queue #(
    .Width ($bits(dword_t)),
    .Depth (TxQueueDepth)
  ) u_tx_q (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (txd_wvalid_i),
    .wdata_i  (txd_wdata_i),
    .wready_o (txd_wready_o),
    .rvalid_o (tx_rvalid),
    .rdata_o  (tx_rdata),
    .rready_i (tx_rready)
  );

  // Software pops RX data and responses
  tti_queue #(
    .Width ($bits(dword_t)),
    .Depth (RxQueueDepth)
  ) u_rx_q (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rx_wvalid),
    .wdata_i  (rx_wdata),
    .wready_o (rx_wready),
    .rvalid_o (rxd_rvalid_o),
    .rdata_o  (rxd_rdata_o),
    .rready_i (rxd_rready_i)
  );

  tti_queue #(
    .Width ($bits(tti_resp_desc_t)),
    .Depth (RespQueueDepth)
  ) u_resp_q (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (resp_wvalid),
    .wdata_i  (resp_wdata),
    .wready_o (resp_wready),
    .rvalid_o (resp_rvalid_o),
    .rdata_o  (resp_rdata_o),
    .rready_i (resp_rready_i)
  );

endmodule

`default_nettype wire

/* src/tti_queue.sv */
// First-word-fall-through FIFO used for each of the target transaction queues
`timescale 1ns/1ps
`default_nettype none

module tti_queue #(
  parameter int Width = 32,
  parameter int Depth = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  input  logic [Width-1:0] wdata_i,
  output logic             wready_o,
  output logic             rvalid_o,
  output logic [Width-1:0] rdata_o,
  input  logic             rready_i
);

  localparam int PtrBits = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntBits = $clog2(Depth + 1);

  logic [Width-1:0]   mem_q [Depth];
  logic [PtrBits-1:0] wptr_q;
  logic [PtrBits-1:0] rptr_q;
  logic [CntBits-1:0] count_q;
  logic               push;
  logic               pop;

  // Pointer advance with wrap at the last entry
  function automatic logic [PtrBits-1:0] next_ptr(input logic [PtrBits-1:0] ptr);
    return (ptr == PtrBits'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wready_o = (count_q != CntBits'(Depth));
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rptr_q];
  assign push     = wvalid_i & wready_o;
  assign pop      = rvalid_o & rready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q] <= wdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) wptr_q <= next_ptr(wptr_q);
      if (pop) rptr_q <= next_ptr(rptr_q);
      // Simultaneous push and pop leaves the occupancy unchanged
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* test/i2c_standby_props.sv */
// Assertions on the standby I2C flow outputs, bound into the flow for every simulation
`timescale 1ns/1ps
`default_nettype none

module i2c_standby_props (
  input logic clk_i,
  input logic rst_ni,
  input logic rx_push_i,
  input logic resp_push_i,
  input logic byte_valid_i,
  input logic cmd_pop_i,
  input logic tx_pop_i,
  input logic err_i
);

  // RX dword and response never push in the same cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(rx_push_i && resp_push_i))
    else $error("RX dword push and response push are high together");

  // Quiet outputs in reset and in the first cycle after it
  assert property (@(posedge clk_i) (!rst_ni || $rose(rst_ni)) |->
      !(rx_push_i || resp_push_i || byte_valid_i || cmd_pop_i || tx_pop_i || err_i))
    else $error("Flow output active during or right after reset");

  // Error is sticky until the next reset
  assert property (@(posedge clk_i) disable iff (!rst_ni) err_i |=> err_i)
    else $error("err_o dropped without a reset");

endmodule

bind i2c_standby_flow i2c_standby_props u_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .rx_push_i    (rx_wvalid_o),
  .resp_push_i  (resp_wvalid_o),
  .byte_valid_i (byte_valid_o),
  .cmd_pop_i    (cmd_rready_o),
  .tx_pop_i     (tx_rready_o),
  .err_i        (err_o)
);

`default_nettype wire

/* test/i2c_standby_tb.sv */
// Table-driven testbench of the standby I2C subsystem, simulated as the top module
`timescale 1ns/1ps
`default_nettype none

module i2c_standby_tb
  import i2c_standby_pkg::*;
();

  localparam int ResetCycles = 10;
  localparam int NumRows     = 16;

  typedef struct packed {
    logic       is_read;
    logic [7:0] nbytes;
    logic       rand_data;
    logic       exp_err;
  } row_t;

  // Kind, byte count, random data, expected error
  localparam row_t Rows [NumRows] = '{
    '{1'b0, 8'd1, 1'b1, 1'b0}, '{1'b0, 8'd2, 1'b1, 1'b0}, '{1'b0, 8'd3, 1'b1, 1'b0},
    '{1'b0, 8'd4, 1'b1, 1'b0}, '{1'b0, 8'd5, 1'b1, 1'b0}, '{1'b0, 8'd8, 1'b1, 1'b0},
    '{1'b0, 8'd9, 1'b1, 1'b0}, '{1'b0, 8'd0, 1'b0, 1'b0}, '{1'b1, 8'd1, 1'b1, 1'b0},
    '{1'b1, 8'd4, 1'b0, 1'b0}, '{1'b1, 8'd7, 1'b1, 1'b0}, '{1'b0, 8'd6, 1'b1, 1'b0},
    '{1'b1, 8'd9, 1'b1, 1'b0}, '{1'b0, 8'd3, 1'b0, 1'b0}, '{1'b1, 8'd0, 1'b0, 1'b1},
    '{1'b1, 8'd6, 1'b1, 1'b1}
  };

  logic           clk_i;
  logic           rst_ni;
  logic           acq_valid_i;
  acq_word_t      acq_word_i;
  logic           byte_valid_o;
  logic [7:0]     byte_data_o;
  logic           byte_ready_i;
  logic           cmd_wvalid_i;
  tti_cmd_desc_t  cmd_wdata_i;
  logic           cmd_wready_o;
  logic           txd_wvalid_i;
  dword_t         txd_wdata_i;
  logic           txd_wready_o;
  logic           rxd_rvalid_o;
  dword_t         rxd_rdata_o;
  logic           rxd_rready_i;
  logic           resp_rvalid_o;
  tti_resp_desc_t resp_rdata_o;
  logic           resp_rready_i;
  logic           err_o;

  int         seed;
  int         checks = 0;
  int         failures = 0;
  int         cycle_cnt = 0;
  int         cycle_limit = 0;
  logic [7:0] data_q [$];

  i2c_standby_top i2c_standby_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles, a transfer never completed", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      failures++;
      $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  // Reference packing is little-endian with zero padding past the last byte
  function automatic dword_t pack_dword(input int first);
    dword_t d;
    d = '0;
    for (int k = 0; k < DwordBytes; k++) begin
      if (first + k < data_q.size()) d[8*k +: 8] = data_q[first + k];
    end
    return d;
  endfunction

  task automatic strobe_acq(input acq_byte_id_e kind, input logic [7:0] value);
    @(posedge clk_i);
    acq_valid_i <= 1'b1;
    acq_word_i  <= '{id: kind, data: value};
    @(posedge clk_i);
    acq_valid_i <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk_i);
    rst_ni <= 1'b0;
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
  endtask

  task automatic pulse_pop(input logic from_rx);
    @(posedge clk_i);
    if (from_rx) rxd_rready_i <= 1'b1;
    else resp_rready_i <= 1'b1;
    @(posedge clk_i);
    rxd_rready_i  <= 1'b0;
    resp_rready_i <= 1'b0;
  endtask

  task automatic run_write(input int n);
    strobe_acq(AcqStart, 8'h00);
    for (int i = 0; i < n; i++) strobe_acq(AcqData, data_q[i]);
    strobe_acq(AcqStop, 8'h00);
    // Response follows the last dword, so all RX data is queued once it shows
    for (int w = 0; w < 20 && !resp_rvalid_o; w++) @(negedge clk_i);
    for (int j = 0; j < (n + 3) / 4; j++) begin
      @(negedge clk_i);
      check_value("rxd_rvalid_o", 32'd1, 32'(rxd_rvalid_o));
      check_value("rxd_rdata_o", pack_dword(4 * j), rxd_rdata_o);
      pulse_pop(1'b1);
    end
    @(negedge clk_i);
    check_value("resp_rvalid_o", 32'd1, 32'(resp_rvalid_o));
    check_value("resp data_length", 32'(n), 32'(resp_rdata_o.data_length));
    check_value("resp err", 32'd0, 32'(resp_rdata_o.err));
    pulse_pop(1'b0);
  endtask

  task automatic run_read(input int n, input logic exp_err);
    logic [31:0] rnd;
    int          want;
    int          got;
    @(posedge clk_i);
    cmd_wvalid_i <= 1'b1;
    cmd_wdata_i  <= '{read: 1'b1, reserved: '0, data_length: xfer_len_t'(n)};
    @(negedge clk_i);
    check_value("cmd_wready_o", 32'd1, 32'(cmd_wready_o));
    @(posedge clk_i);
    cmd_wvalid_i <= 1'b0;
    for (int j = 0; j < (n + 3) / 4; j++) begin
      txd_wvalid_i <= 1'b1;
      txd_wdata_i  <= pack_dword(4 * j);
      @(negedge clk_i);
      check_value("txd_wready_o", 32'd1, 32'(txd_wready_o));
      @(posedge clk_i);
    end
    txd_wvalid_i <= 1'b0;
    strobe_acq(AcqRestart, 8'h00);
    // A NACK row stops after two bytes
    want = (exp_err && n > 2) ? 2 : n;
    got  = 0;
    while (got < want) begin
      @(posedge clk_i);
      rnd = $random(seed);
      byte_ready_i <= (rnd[1:0] != 2'b00);
      @(negedge clk_i);
      if (byte_valid_o && byte_ready_i) begin
        check_value("byte_data_o", 32'(data_q[got]), 32'(byte_data_o));
        got++;
      end
    end
    @(posedge clk_i);
    byte_ready_i <= 1'b0;
    if (exp_err) begin
      if (n > 0) strobe_acq(AcqNack, 8'h00);
      for (int w = 0; w < 20 && !err_o; w++) @(negedge clk_i);
      check_value("err_o", 32'd1, 32'(err_o));
      repeat (5) @(negedge clk_i);
      strobe_acq(AcqStop, 8'h00);
      @(negedge clk_i);
      check_value("err_o held", 32'd1, 32'(err_o));
    end else begin
      @(negedge clk_i);
      check_value("byte_valid_o after last byte", 32'd0, 32'(byte_valid_o));
      strobe_acq(AcqStop, 8'h00);
      repeat (2) @(negedge clk_i);
    end
  endtask

  task automatic check_empty();
    @(negedge clk_i);
    check_value("cmd queue rvalid", 32'd0, 32'(i2c_standby_top_i.cmd_rvalid));
    check_value("tx queue rvalid", 32'd0, 32'(i2c_standby_top_i.tx_rvalid));
    check_value("rxd_rvalid_o", 32'd0, 32'(rxd_rvalid_o));
    check_value("resp_rvalid_o", 32'd0, 32'(resp_rvalid_o));
    check_value("err_o", 32'd0, 32'(err_o));
  endtask

  initial begin
    int          fails_before;
    int          n;
    logic [31:0] rnd;
    seed          = 32'hccaa_acd8;
    rst_ni        = 1'b0;
    acq_valid_i   = 1'b0;
    acq_word_i    = '{id: AcqData, data: 8'h00};
    byte_ready_i  = 1'b0;
    cmd_wvalid_i  = 1'b0;
    cmd_wdata_i   = '0;
    txd_wvalid_i  = 1'b0;
    txd_wdata_i   = '0;
    rxd_rready_i  = 1'b0;
    resp_rready_i = 1'b0;
    cycle_limit   = ResetCycles;
    for (int r = 0; r < NumRows; r++) begin
      cycle_limit += 40 + 12 * int'(Rows[r].nbytes);
      if (Rows[r].exp_err) cycle_limit += ResetCycles;
    end
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int r = 0; r < NumRows; r++) begin
      fails_before = failures;
      n = int'(Rows[r].nbytes);
      if (Rows[r].exp_err) apply_reset();
      data_q.delete();
      for (int i = 0; i < n; i++) begin
        rnd = $random(seed);
        data_q.push_back(Rows[r].rand_data ? rnd[7:0] : 8'(8'h10 + i));
      end
      if (Rows[r].is_read) run_read(n, Rows[r].exp_err);
      else run_write(n);
      if (!Rows[r].exp_err) check_empty();
      $display("Row %0d %s of %0d bytes: %s", r, Rows[r].is_read ? "read" : "write", n,
               (failures == fails_before) ? "ok" : "mismatch");
    end
    $display("Done: %0d checks, %0d failed", checks, failures);
    if (failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
